//--- design/hello_types_pkg.sv
//---------------------------------------------------------------------
// Hello-world control block types
// Plain vector typedefs for the host bus, LED and counter widths,
// plus the host handshake FSM state encoding
//---------------------------------------------------------------------

`default_nettype none

package hello_types_pkg;

  //-------------------------------------------------------------------
  // Host bus
  //-------------------------------------------------------------------
  // Byte offset into the register map
  typedef logic [7:0]  reg_addr_t;
  // Host read and write data word
  typedef logic [31:0] reg_data_t;

  //-------------------------------------------------------------------
  // LED and counter widths
  //-------------------------------------------------------------------
  // Virtual LEDs and virtual DIP switches
  typedef logic [15:0] led_t;
  // Prescale compare value and prescale count
  typedef logic [7:0]  tick_t;
  // Main count, load value and watermark
  typedef logic [15:0] count_t;

  // Four-phase handshake states
  typedef enum logic [1:0] {
    access_idle,
    access_ack,
    access_release
  } access_state_t;

endpackage

`default_nettype wire

//--- design/hello_regmap_pkg.sv
//---------------------------------------------------------------------
// Hello-world control block register map
// Offsets, counter control and status bit positions, reset values
// and the word returned for unmapped offsets
//---------------------------------------------------------------------

`default_nettype none

package hello_regmap_pkg;

  import hello_types_pkg::*;

  //-------------------------------------------------------------------
  // Register offsets
  //-------------------------------------------------------------------
  localparam reg_addr_t hello_world_addr   = 8'h00;
  // Read only, LED shadow zero-extended
  localparam reg_addr_t vled_addr          = 8'h04;
  localparam reg_addr_t cnt_ctrl_addr      = 8'h08;
  localparam reg_addr_t cnt_load_addr      = 8'h0C;
  localparam reg_addr_t cnt_watermark_addr = 8'h10;
  // Read only, packed counter status
  localparam reg_addr_t cnt_status_addr    = 8'h14;

  //-------------------------------------------------------------------
  // Counter control bits
  //-------------------------------------------------------------------
  localparam int unsigned ctrl_enable_bit  = 0;
  localparam int unsigned ctrl_load_bit    = 1;
  localparam int unsigned ctrl_clear_bit   = 2;
  localparam int unsigned ctrl_oneshot_bit = 3;
  // Prescale value sits in bits 15:8
  localparam int unsigned ctrl_tick_lsb    = 8;

  // Counter status bits, count itself in 15:0
  localparam int unsigned status_ge_bit   = 16;
  localparam int unsigned status_tick_bit = 17;

  //-------------------------------------------------------------------
  // Values
  //-------------------------------------------------------------------
  localparam reg_data_t unimpl_value = 32'hDEAD_BEEF;

  // Reset words, everything comes up cleared
  localparam reg_data_t hello_world_rst_value   = 32'h0000_0000;
  localparam reg_data_t cnt_ctrl_rst_value      = 32'h0000_0000;
  localparam reg_data_t cnt_load_rst_value      = 32'h0000_0000;
  localparam reg_data_t cnt_watermark_rst_value = 32'h0000_0000;

endpackage

`default_nettype wire

//--- design/host_reg_file.sv
//---------------------------------------------------------------------
// Host register file
// Four-phase req/ack slave with hello-world, counter control, load
// and watermark storage and a registered read multiplexer
//---------------------------------------------------------------------

`default_nettype none

module host_reg_file
  import hello_types_pkg::*;
  import hello_regmap_pkg::*;
(
  input  wire logic      clk_main_a0,
  input  wire logic      rst_main_n_sync,
  // Host port
  input  wire logic      req,
  input  wire logic      wr,
  input  wire reg_addr_t addr,
  input  wire reg_data_t wdata,
  output logic           ack,
  output reg_data_t      rdata,
  // Status from LED block and counter
  input  wire led_t      vled_reg,
  input  wire count_t    count,
  input  wire logic      ge_watermark,
  input  wire logic      tick,
  // Held register levels
  output led_t           hello_low,
  output logic           enable,
  output logic           load,
  output logic           clear,
  output logic           oneshot,
  output tick_t          tick_value,
  output count_t         load_value,
  output count_t         watermark
);

  access_state_t state_q;
  reg_data_t     hello_world_q;
  reg_data_t     hello_swapped;
  reg_data_t     ctrl_word;
  reg_data_t     status_word;
  reg_data_t     read_word;
  logic          access_start;
  logic          wr_en;
  logic          rd_en;

  //-------------------------------------------------------------------
  // Handshake FSM
  //-------------------------------------------------------------------
  // New access only accepted from idle
  assign access_start = (state_q == access_idle) && req;
  assign wr_en        = access_start && wr;
  assign rd_en        = access_start && !wr;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= access_idle;
    end else begin
      case (state_q)
        access_idle: begin
          if (req) begin
            state_q <= access_ack;
          end
        end
        // Hold ack until host lets go of req
        access_ack: begin
          if (!req) begin
            state_q <= access_release;
          end
        end
        // One dead cycle before the next access
        access_release: begin
          state_q <= access_idle;
        end
        default: begin
          state_q <= access_idle;
        end
      endcase
    end
  end

  // Ack is high for the whole ack state
  assign ack = (state_q == access_ack);

  //-------------------------------------------------------------------
  // Register storage
  //-------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= hello_world_rst_value;
      enable        <= cnt_ctrl_rst_value[ctrl_enable_bit];
      load          <= cnt_ctrl_rst_value[ctrl_load_bit];
      clear         <= cnt_ctrl_rst_value[ctrl_clear_bit];
      oneshot       <= cnt_ctrl_rst_value[ctrl_oneshot_bit];
      tick_value    <= cnt_ctrl_rst_value[ctrl_tick_lsb +: $bits(tick_t)];
      load_value    <= cnt_load_rst_value[$bits(count_t)-1:0];
      watermark     <= cnt_watermark_rst_value[$bits(count_t)-1:0];
    end else if (wr_en) begin
      // Read-only and unmapped offsets fall through
      case (addr)
        hello_world_addr: begin
          hello_world_q <= wdata;
        end
        cnt_ctrl_addr: begin
          enable     <= wdata[ctrl_enable_bit];
          load       <= wdata[ctrl_load_bit];
          clear      <= wdata[ctrl_clear_bit];
          oneshot    <= wdata[ctrl_oneshot_bit];
          tick_value <= wdata[ctrl_tick_lsb +: $bits(tick_t)];
        end
        cnt_load_addr: begin
          load_value <= wdata[$bits(count_t)-1:0];
        end
        cnt_watermark_addr: begin
          watermark <= wdata[$bits(count_t)-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // Low half feeds the LED shadow
  assign hello_low = hello_world_q[$bits(led_t)-1:0];

  //-------------------------------------------------------------------
  // Read path
  //-------------------------------------------------------------------
  // Hello-world reads back with byte order reversed
  assign hello_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                          hello_world_q[23:16], hello_world_q[31:24]};

  always_comb begin
    // Repack control fields at their bit positions
    ctrl_word                                   = '0;
    ctrl_word[ctrl_enable_bit]                  = enable;
    ctrl_word[ctrl_load_bit]                    = load;
    ctrl_word[ctrl_clear_bit]                   = clear;
    ctrl_word[ctrl_oneshot_bit]                 = oneshot;
    ctrl_word[ctrl_tick_lsb +: $bits(tick_t)]   = tick_value;
    // Count in the low half, flags above it
    status_word                                 = '0;
    status_word[$bits(count_t)-1:0]             = count;
    status_word[status_ge_bit]                  = ge_watermark;
    status_word[status_tick_bit]                = tick;
  end

  always_comb begin
    case (addr)
      hello_world_addr:   read_word = hello_swapped;
      vled_addr:          read_word = reg_data_t'(vled_reg);
      cnt_ctrl_addr:      read_word = ctrl_word;
      cnt_load_addr:      read_word = reg_data_t'(load_value);
      cnt_watermark_addr: read_word = reg_data_t'(watermark);
      cnt_status_addr:    read_word = status_word;
      default:            read_word = unimpl_value;
    endcase
  end

  // Captured with ack rise, stable for the ack phase
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= read_word;
    end
  end

endmodule

`default_nettype wire

//--- design/vled_status.sv
//---------------------------------------------------------------------
// Virtual LED status
// Shadows the low half of hello-world and drives the LED outputs
// masked by the synchronized virtual DIP switches
//---------------------------------------------------------------------

`default_nettype none

module vled_status
  import hello_types_pkg::*;
(
  input  wire logic clk_main_a0,
  input  wire logic rst_main_n_sync,
  input  wire led_t hello_low,
  input  wire led_t vdip,
  output led_t      vled_reg,
  output led_t      vled
);

  // Two-flop synchronizer stages
  led_t vdip_q1;
  led_t vdip_q2;

  //-------------------------------------------------------------------
  // DIP switch synchronizer
  //-------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  //-------------------------------------------------------------------
  // LED shadow and output
  //-------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_reg <= '0;
      vled     <= '0;
    end else begin
      // Follows hello-world one cycle late
      vled_reg <= hello_low;
      // Switch off means LED dark
      vled     <= vled_reg & vdip_q2;
    end
  end

endmodule

`default_nettype wire

//--- design/tick_counter.sv
//---------------------------------------------------------------------
// Tick counter
// Prescaler that advances a 16-bit main count, with clear, load,
// one-shot saturation and a registered watermark flag
//---------------------------------------------------------------------

`default_nettype none

module tick_counter
  import hello_types_pkg::*;
(
  input  wire logic   clk_main_a0,
  input  wire logic   rst_main_n_sync,
  input  wire logic   enable,
  input  wire logic   load,
  input  wire logic   clear,
  input  wire logic   oneshot,
  input  wire tick_t  tick_value,
  input  wire count_t load_value,
  input  wire count_t watermark,
  output count_t      count,
  output logic        ge_watermark,
  output logic        tick
);

  tick_t tick_cnt;
  logic  tick_wrap;
  logic  count_at_max;

  // Prescaler reaches its compare value this cycle
  assign tick_wrap    = enable && (tick_cnt >= tick_value);
  // One-shot stops here
  assign count_at_max = (count == '1);

  //-------------------------------------------------------------------
  // Prescaler
  //-------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else if (clear) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end else begin
      tick <= tick_wrap;
      if (tick_wrap) begin
        tick_cnt <= '0;
      end else if (enable) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  //-------------------------------------------------------------------
  // Main counter
  //-------------------------------------------------------------------
  // Priority is clear, then load, then counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (tick_wrap && !(oneshot && count_at_max)) begin
      // Free-running mode wraps through zero
      count <= count + 1'b1;
    end
  end

  // Watermark flag, one cycle behind count
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ge_watermark <= 1'b0;
    end else begin
      ge_watermark <= (count >= watermark);
    end
  end

endmodule

`default_nettype wire

//--- design/hello_top.sv
//---------------------------------------------------------------------
// Hello-world control block top level
// Connects the host register file, LED status and tick counter
//---------------------------------------------------------------------

`default_nettype none

module hello_top
  import hello_types_pkg::*;
(
  input  wire logic      clk_main_a0,
  input  wire logic      rst_main_n_sync,
  // Host req/ack port
  input  wire logic      req,
  input  wire logic      wr,
  input  wire reg_addr_t addr,
  input  wire reg_data_t wdata,
  output logic           ack,
  output reg_data_t      rdata,
  // Virtual switches and LEDs
  input  wire led_t      vdip,
  output led_t           vled
);

  //-------------------------------------------------------------------
  // Internal wiring
  //-------------------------------------------------------------------
  // Register file to LED block and back
  led_t   hello_low;
  led_t   vled_reg;
  // Counter controls
  logic   enable;
  logic   load;
  logic   clear;
  logic   oneshot;
  tick_t  tick_value;
  count_t load_value;
  count_t watermark;
  // Counter status
  count_t count;
  logic   ge_watermark;
  logic   tick;

  host_reg_file i_host_reg_file (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (req),
    .wr              (wr),
    .addr            (addr),
    .wdata           (wdata),
    .ack             (ack),
    .rdata           (rdata),
    .vled_reg        (vled_reg),
    .count           (count),
    .ge_watermark    (ge_watermark),
    .tick            (tick),
    .hello_low       (hello_low),
    .enable          (enable),
    .load            (load),
    .clear           (clear),
    .oneshot         (oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark)
  );

  vled_status i_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .vled_reg        (vled_reg),
    .vled            (vled)
  );

  tick_counter i_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .enable          (enable),
    .load            (load),
    .clear           (clear),
    .oneshot         (oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .count           (count),
    .ge_watermark    (ge_watermark),
    .tick            (tick)
  );

endmodule

`default_nettype wire

//--- bench/hello_tb.sv
//---------------------------------------------------------------------
// Hello-world control block testbench
// Directed tests over the four-phase host port, checking register
// reads, LED masking and the tick counter against the register map
//---------------------------------------------------------------------

`default_nettype none

module hello_tb
  import hello_types_pkg::*;
  import hello_regmap_pkg::*;
();

  //-------------------------------------------------------------------
  // Timing and run length
  //-------------------------------------------------------------------
  localparam int clk_period    = 10;
  localparam int reset_cycles  = 8;
  // Bound on any single handshake phase
  localparam int ack_timeout   = 16;
  localparam int led_settle    = 4;
  localparam int count_wait    = 100;
  localparam int oneshot_wait  = 20;
  // Rough access budget over all tests
  localparam int access_count  = 40;
  localparam int access_cycles = 6;
  localparam int watchdog_cycles = reset_cycles + access_count * access_cycles +
                                   3 * led_settle + count_wait + oneshot_wait + 200;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  logic      req;
  logic      wr;
  reg_addr_t addr;
  reg_data_t wdata;
  logic      ack;
  reg_data_t rdata;
  led_t      vdip;
  led_t      vled;

  // LFSR state and values shared between tests
  logic [15:0] lfsr_state;
  reg_data_t   hello_word;
  count_t      watermark_value;

  hello_top i_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (req),
    .wr              (wr),
    .addr            (addr),
    .wdata           (wdata),
    .ack             (ack),
    .rdata           (rdata),
    .vdip            (vdip),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #(clk_period / 2) clk_main_a0 = ~clk_main_a0;
  end

  //-------------------------------------------------------------------
  // Random data and failure handling
  //-------------------------------------------------------------------
  // 16-bit Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  // One LFSR step per bit taken, MSB first
  function automatic reg_data_t rand_bits(input int unsigned n);
    reg_data_t value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_led(input string name, input led_t got, input led_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Status word as the register map lays it out
  function automatic reg_data_t expected_status(input count_t c, input logic ge,
                                                input logic tk);
    reg_data_t value;
    value                  = '0;
    value[15:0]            = c;
    value[status_ge_bit]   = ge;
    value[status_tick_bit] = tk;
    return value;
  endfunction

  //-------------------------------------------------------------------
  // Host bus tasks
  //-------------------------------------------------------------------
  // Every task starts and ends one time unit after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk_main_a0);
      #1;
    end
  endtask

  task automatic bus_access(input logic write, input reg_addr_t a, input reg_data_t d,
                            output reg_data_t rd);
    int cycles;
    req   = 1'b1;
    wr    = write;
    addr  = a;
    wdata = d;
    cycles = 0;
    do begin
      step_cycles(1);
      cycles = cycles + 1;
    end while (!ack && cycles < ack_timeout);
    if (!ack) begin
      fail_run($sformatf("Handshake error, ack never rose for offset 0x%h", a));
    end
    // Read data is valid while ack is high
    rd  = rdata;
    req = 1'b0;
    cycles = 0;
    do begin
      step_cycles(1);
      cycles = cycles + 1;
    end while (ack && cycles < ack_timeout);
    if (ack) begin
      fail_run($sformatf("Handshake error, ack never fell for offset 0x%h", a));
    end
  endtask

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    reg_data_t unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic bus_read(input reg_addr_t a, output reg_data_t rd);
    bus_access(1'b0, a, '0, rd);
  endtask

  task automatic expect_read(input reg_addr_t a, input reg_data_t exp, input string name);
    reg_data_t got;
    bus_read(a, got);
    check_data(name, got, exp);
  endtask

  //-------------------------------------------------------------------
  // Directed tests
  //-------------------------------------------------------------------
  task automatic test_reset_values();
    check_led("vled", vled, '0);
    expect_read(hello_world_addr, '0, "hello_world");
    expect_read(vled_addr, '0, "vled_reg");
    expect_read(cnt_ctrl_addr, '0, "cnt_ctrl");
    expect_read(cnt_load_addr, '0, "cnt_load");
    expect_read(cnt_watermark_addr, '0, "cnt_watermark");
    // Count and watermark both zero, so ge comes up set
    expect_read(cnt_status_addr, expected_status('0, 1'b1, 1'b0), "cnt_status");
    // Gap in the map
    expect_read(8'h18, unimpl_value, "unmapped");
  endtask

  task automatic test_hello_world();
    reg_data_t swapped;
    hello_word = rand_bits(32);
    swapped    = {hello_word[7:0], hello_word[15:8], hello_word[23:16], hello_word[31:24]};
    bus_write(hello_world_addr, hello_word);
    expect_read(hello_world_addr, swapped, "hello_world");
    expect_read(vled_addr, {16'h0000, hello_word[15:0]}, "vled_reg");
    // LED register ignores writes
    bus_write(vled_addr, ~hello_word);
    expect_read(vled_addr, {16'h0000, hello_word[15:0]}, "vled_reg after write");
    expect_read(hello_world_addr, swapped, "hello_world after vled write");
  endtask

  task automatic test_led_mask();
    led_t dip;
    dip  = led_t'(rand_bits(16));
    vdip = dip;
    step_cycles(led_settle);
    check_led("vled", vled, hello_word[15:0] & dip);
    // New switch pattern
    dip  = led_t'(rand_bits(16));
    vdip = dip;
    step_cycles(led_settle);
    check_led("vled after vdip change", vled, hello_word[15:0] & dip);
    // New hello-world word under the same switches
    hello_word = rand_bits(32);
    bus_write(hello_world_addr, hello_word);
    step_cycles(led_settle);
    check_led("vled after hello write", vled, hello_word[15:0] & dip);
  endtask

  task automatic test_load_clear();
    count_t    load_word;
    reg_data_t ctrl_load;
    load_word = count_t'(rand_bits(16));
    ctrl_load = 32'h1 << ctrl_load_bit;
    bus_write(cnt_load_addr, reg_data_t'(load_word));
    expect_read(cnt_load_addr, reg_data_t'(load_word), "cnt_load");
    bus_write(cnt_ctrl_addr, ctrl_load);
    expect_read(cnt_ctrl_addr, ctrl_load, "cnt_ctrl");
    bus_write(cnt_ctrl_addr, '0);
    // Watermark is still zero, so ge is set
    expect_read(cnt_status_addr, expected_status(load_word, 1'b1, 1'b0), "cnt_status load");
    bus_write(cnt_ctrl_addr, 32'h1 << ctrl_clear_bit);
    bus_write(cnt_ctrl_addr, '0);
    expect_read(cnt_status_addr, expected_status('0, 1'b1, 1'b0), "cnt_status clear");
  endtask

  task automatic test_count_watermark();
    reg_data_t first;
    reg_data_t second;
    count_t    counted;
    tick_t     tick_sel;
    tick_sel        = 8'd3;
    watermark_value = count_t'(rand_bits(6));
    bus_write(cnt_watermark_addr, reg_data_t'(watermark_value));
    expect_read(cnt_watermark_addr, reg_data_t'(watermark_value), "cnt_watermark");
    bus_write(cnt_ctrl_addr, 32'h1 << ctrl_clear_bit);
    bus_write(cnt_ctrl_addr, (32'h1 << ctrl_enable_bit) |
                             (reg_data_t'(tick_sel) << ctrl_tick_lsb));
    step_cycles(count_wait);
    bus_write(cnt_ctrl_addr, '0);
    // Disabled counter must hold still
    bus_read(cnt_status_addr, first);
    bus_read(cnt_status_addr, second);
    check_data("cnt_status second read", second, first);
    counted = first[15:0];
    if (counted == '0) begin
      fail_run("Main counter stayed at zero while enabled");
    end
    check_data("cnt_status", first,
               expected_status(counted, counted >= watermark_value, 1'b0));
  endtask

  task automatic test_oneshot();
    bus_write(cnt_load_addr, 32'h0000_FFFE);
    bus_write(cnt_ctrl_addr, 32'h1 << ctrl_load_bit);
    // Tick value zero, so a tick every cycle
    bus_write(cnt_ctrl_addr, (32'h1 << ctrl_enable_bit) | (32'h1 << ctrl_oneshot_bit));
    step_cycles(oneshot_wait);
    bus_write(cnt_ctrl_addr, '0);
    expect_read(cnt_status_addr,
                expected_status(16'hFFFF, 16'hFFFF >= watermark_value, 1'b0),
                "cnt_status oneshot");
  endtask

  //-------------------------------------------------------------------
  // Main sequence and watchdog
  //-------------------------------------------------------------------
  initial begin
    rst_main_n_sync = 1'b0;
    req             = 1'b0;
    wr              = 1'b0;
    addr            = '0;
    wdata           = '0;
    vdip            = '0;
    lfsr_state      = 16'd49;
    hello_word      = '0;
    watermark_value = '0;
    repeat (reset_cycles) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    test_reset_values();
    test_hello_world();
    test_led_mask();
    test_load_clear();
    test_count_watermark();
    test_oneshot();
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_main_a0);
    fail_run($sformatf("Watchdog timeout, tests still running after %0d cycles",
                       watchdog_cycles));
  end

endmodule

`default_nettype wire

//--- sim.f
design/hello_types_pkg.sv
design/hello_regmap_pkg.sv
design/host_reg_file.sv
design/vled_status.sv
design/tick_counter.sv
design/hello_top.sv
bench/hello_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hello-world control block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module hello_tb -f sim.f --Mdir obj_dir -o sim_hello

# A failing run exits nonzero, the search below decides the result
output=$(./obj_dir/sim_hello 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
  exit 0
else
  echo "Simulation did not report a pass"
  exit 1
fi
